/* bench/exu_props.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_props (
  input logic                       clock,
  input logic                       rst_n,
  input logic                       result_valid,
  input exu_op_pkg::exu_tag_t       result_dest,
  input logic                       result_credit,
  input logic [`EXU_RS_DEPTH-1:0]   rs_valid,
  input logic                       alloc_valid,
  input logic                       free_pulse
);

  // Results broadcast and not yet credited back by the reorder buffer
  int owed;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      owed <= 0;
    end else begin
      owed <= owed + int'(result_valid) - int'(result_credit);
    end
  end

  credit_held: assert property (@(posedge clock) disable iff (!rst_n)
    result_valid |-> owed < `EXU_RESULT_CREDITS)
    else $error("result broadcast with no reorder-buffer credit");

  tag_nonzero: assert property (@(posedge clock) disable iff (!rst_n)
    result_valid |-> result_dest != '0)
    else $error("result broadcast carries tag 0");

  // Occupancy grows per allocation and shrinks per credit returned
  occupancy: assert property (@(posedge clock) disable iff (!rst_n)
    $countones(rs_valid) == $countones($past(rs_valid)) + int'($past(alloc_valid))
                            - int'($past(free_pulse)))
    else $error("dispatch credits do not match the entries freed");

endmodule

/* bench/exu_stim.txt */
# sec op vj qj vk qk dest expected (hex); sec 0=alu 1=mul 2=dep 3=stall
# qj/qk name an earlier dest, 0 means the v column holds the operand
0 0 00000005 0 00000003 0 1 00000008
0 1 00000003 0 00000005 0 2 fffffffe
0 2 f0f0f0f0 0 0ff00ff0 0 3 00f000f0
0 3 f0f0f0f0 0 0ff00ff0 0 4 fff0fff0
0 4 f0f0f0f0 0 0ff00ff0 0 5 ff00ff00
0 5 00000001 0 00000024 0 6 00000010
0 6 80000000 0 0000001f 0 7 00000001
0 7 80000000 0 00000004 0 8 f8000000
0 8 ffffffff 0 00000001 0 9 00000001
0 9 ffffffff 0 00000001 0 a 00000000
1 e 12345678 0 00000010 0 b 23456780
1 f ffffffff 0 ffffffff 0 c fffffffe
2 e 00000003 0 00000007 0 d 00000015
2 0 00000000 d 00000100 0 e 00000115
2 e 00000000 e 00000002 0 f 0000022a
2 1 00000000 f 00000000 e 1 00000115
2 4 00000000 1 ffffffff 0 2 fffffeea
2 f 00000000 2 00000010 0 3 0000000f
2 8 00000000 3 00000000 e 4 00000001
2 5 00000000 4 0000001f 0 5 80000000
2 7 00000000 5 00000008 0 6 ff800000
3 0 00000001 0 00000001 0 7 00000002
3 3 00000100 0 00000011 0 8 00000111
3 e 0000ffff 0 0000ffff 0 9 fffe0001
3 2 00000000 9 0000ffff 0 a 00000001
3 6 00000000 8 00000004 0 b 00000011
3 9 00000000 7 00000000 a c 00000000
3 0 00000000 c 00000000 b d 00000011
3 f 80000000 0 00000004 0 e 00000002

/* bench/exu_tb.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_tb;
  import exu_op_pkg::*;
  import exu_bus_pkg::*;

  logic        clock;
  logic        rst_n;
  logic        dispatch_valid;
  exu_uop_t    dispatch_uop;
  logic        dispatch_credit;
  logic        result_valid;
  exu_result_t result;
  logic        result_credit;
  logic        credit_overrun;

  logic [31:0] sec_arr[64];
  logic [31:0] op_arr[64];
  logic [31:0] vj_arr[64];
  logic [31:0] qj_arr[64];
  logic [31:0] vk_arr[64];
  logic [31:0] qk_arr[64];
  logic [31:0] dest_arr[64];
  logic [31:0] exp_arr[64];

  logic        busy_tag[16];
  logic [31:0] exp_by_tag[16];
  logic [31:0] val_by_tag[16];
  logic [31:0] sec_by_tag[16];

  int          num_ops;
  int          next_idx;
  int          got_count;
  int          returned;
  int          disp_credits;
  int          fail_count;
  int          cyc;
  int          tcount;
  int          limit;
  int          due_q[$];
  logic [31:0] lcg_state;
  logic        running;
  logic        passed;

  exu_top uut (
    .clock           (clock),
    .rst_n           (rst_n),
    .dispatch_valid  (dispatch_valid),
    .dispatch_uop    (dispatch_uop),
    .dispatch_credit (dispatch_credit),
    .result_valid    (result_valid),
    .result          (result),
    .result_credit   (result_credit),
    .credit_overrun  (credit_overrun)
  );

  bind exu_writeback exu_props wb_props (
    .clock(clock), .rst_n(rst_n), .result_valid(result_valid), .result_dest(result.dest),
    .result_credit(result_credit), .rs_valid('0), .alloc_valid(1'b0), .free_pulse(1'b0)
  );

  bind exu_rs exu_props rs_props (
    .clock(clock), .rst_n(rst_n), .result_valid(1'b0), .result_dest('0),
    .result_credit(1'b0), .rs_valid(rs_valid), .alloc_valid(alloc_valid),
    .free_pulse(free_pulse)
  );

  always #4 clock = ~clock;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic string sec_name(input logic [31:0] s);
    case (s)
      0: return "alu";
      1: return "mul";
      2: return "dep";
      default: return "stall";
    endcase
  endfunction

  task automatic stop_on_error(input string msg);
    fail_count++;
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic load_stim();
    int    fd;
    int    r;
    string line;
    fd = $fopen("bench/exu_stim.txt", "r");
    assert (fd != 0) else stop_on_error("Could not open the stimulus file");
    num_ops = 0;
    while (!$feof(fd)) begin
      r = $fgets(line, fd);
      if (r > 0 && line.len() > 0 && line[0] != "#") begin
        r = $sscanf(line, "%h %h %h %h %h %h %h %h", sec_arr[num_ops], op_arr[num_ops],
                    vj_arr[num_ops], qj_arr[num_ops], vk_arr[num_ops], qk_arr[num_ops],
                    dest_arr[num_ops], exp_arr[num_ops]);
        if (r == 8) begin
          num_ops++;
        end
      end
    end
    $fclose(fd);
  endtask

  // Results, credit returns and dispatch on the falling edge
  always @(negedge clock) begin
    exu_uop_t u;
    int       gap;
    int       t;
    if (running) begin
      cyc++;
      if (result_valid) begin
        t = int'(result.dest);
        assert (t != 0 && busy_tag[t])
          else stop_on_error("A result arrived for a tag with no micro-op in flight");
        assert (result.value == exp_by_tag[t])
          else stop_on_error($sformatf("MISMATCH test=%s tag=%0d expected=%08h actual=%08h",
                                       sec_name(sec_by_tag[t]), t, exp_by_tag[t],
                                       result.value));
        busy_tag[t]   = 1'b0;
        val_by_tag[t] = result.value;
        got_count++;
        assert (got_count - returned <= `EXU_RESULT_CREDITS)
          else stop_on_error("More results arrived than result credits allowed");
        lcg_state = lcg_next(lcg_state);
        gap = (sec_by_tag[t] == 3) ? 40 : int'((lcg_state >> 16) % 4);
        due_q.push_back(cyc + gap);
      end
      if (dispatch_credit) begin
        disp_credits++;
        assert (disp_credits <= `EXU_RS_DEPTH)
          else stop_on_error("More dispatch credits came back than were spent");
      end
      assert (!credit_overrun) else stop_on_error("The DUT flagged a dispatch credit overrun");
      result_credit = 1'b0;
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        void'(due_q.pop_front());
        result_credit = 1'b1;
        returned++;
      end
      dispatch_valid = 1'b0;
      if (next_idx < num_ops && disp_credits > 0 && !busy_tag[dest_arr[next_idx][3:0]]) begin
        u.op   = exu_op_e'(op_arr[next_idx][3:0]);
        u.vj   = vj_arr[next_idx];
        u.qj   = exu_tag_t'(qj_arr[next_idx]);
        u.vk   = vk_arr[next_idx];
        u.qk   = exu_tag_t'(qk_arr[next_idx]);
        u.dest = exu_tag_t'(dest_arr[next_idx]);
        // Producer already broadcast, so forward its value like a register file
        if (u.qj != '0 && !busy_tag[u.qj]) begin
          u.vj = val_by_tag[u.qj];
          u.qj = '0;
        end
        if (u.qk != '0 && !busy_tag[u.qk]) begin
          u.vk = val_by_tag[u.qk];
          u.qk = '0;
        end
        busy_tag[u.dest]   = 1'b1;
        exp_by_tag[u.dest] = exp_arr[next_idx];
        sec_by_tag[u.dest] = sec_arr[next_idx];
        dispatch_uop   = u;
        dispatch_valid = 1'b1;
        disp_credits--;
        next_idx++;
      end
    end
  end

  always @(posedge clock) begin
    if (running) begin
      tcount++;
      if (tcount > limit) begin
        fail_count++;
        $display("Timeout: not all results arrived within %0d cycles", limit);
        $display("Simulation failed");
        $fatal(1);
      end
    end
  end

  initial begin
    clock          = 1'b0;
    rst_n          = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_uop   = '0;
    result_credit  = 1'b0;
    running        = 1'b0;
    passed         = 1'b0;
    next_idx       = 0;
    got_count      = 0;
    returned       = 0;
    fail_count     = 0;
    cyc            = 0;
    tcount         = 0;
    disp_credits   = `EXU_RS_DEPTH;
    lcg_state      = 32'd65162;
    for (int i = 0; i < 16; i++) begin
      busy_tag[i]   = 1'b0;
      exp_by_tag[i] = '0;
      val_by_tag[i] = '0;
      sec_by_tag[i] = '0;
    end
    load_stim();
    limit = 200 * num_ops + 1000;
    repeat (16) @(posedge clock);
    @(negedge clock);
    rst_n   = 1'b1;
    running = 1'b1;
    wait (got_count == num_ops);
    // Extra cycles catch any duplicate result
    repeat (6) @(negedge clock);
    assert (disp_credits == `EXU_RS_DEPTH)
      else stop_on_error("Not all dispatch credits came back");
    if (fail_count == 0) begin
      passed = 1'b1;
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1);
    end
  end

  // Bound assertion failures end the run without the checks above
  final begin
    if (!passed && fail_count == 0) begin
      $display("Simulation failed");
    end
  end

endmodule

/* rtl/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu (
  input  logic                     alu_issue_valid,
  input  exu_bus_pkg::exu_issue_t  alu_issue,
  output logic                     alu_out_valid,
  output exu_bus_pkg::exu_result_t alu_out
);
  import exu_op_pkg::*;

  exu_word_t a;
  exu_word_t b;
  logic [4:0] shamt;

  assign a     = alu_issue.a;
  assign b     = alu_issue.b;
  assign shamt = b[4:0];

  assign alu_out_valid = alu_issue_valid;
  assign alu_out.dest  = alu_issue.dest;

  always_comb begin
    case (alu_issue.op)
      op_add:  alu_out.value = a + b;
      op_sub:  alu_out.value = a - b;
      op_and:  alu_out.value = a & b;
      op_or:   alu_out.value = a | b;
      op_xor:  alu_out.value = a ^ b;
      op_sll:  alu_out.value = a << shamt;
      op_srl:  alu_out.value = a >> shamt;
      op_sra:  alu_out.value = exu_word_t'($signed(a) >>> shamt);
      op_slt:  alu_out.value = exu_word_t'($signed(a) < $signed(b));
      op_sltu: alu_out.value = exu_word_t'(a < b);
      // Multiplies never reach this unit
      default: alu_out.value = '0;
    endcase
  end

endmodule

/* rtl/exu_bus_pkg.sv */
package exu_bus_pkg;

  // Dispatched micro-op, 80 bits
  typedef struct packed {
    exu_op_pkg::exu_op_e   op;
    exu_op_pkg::exu_word_t vj;
    exu_op_pkg::exu_tag_t  qj;
    exu_op_pkg::exu_word_t vk;
    exu_op_pkg::exu_tag_t  qk;
    exu_op_pkg::exu_tag_t  dest;
  } exu_uop_t;

  // Issued to a unit with both operands resolved, 72 bits
  typedef struct packed {
    exu_op_pkg::exu_op_e   op;
    exu_op_pkg::exu_word_t a;
    exu_op_pkg::exu_word_t b;
    exu_op_pkg::exu_tag_t  dest;
  } exu_issue_t;

  // Result bus payload, 36 bits
  typedef struct packed {
    exu_op_pkg::exu_tag_t  dest;
    exu_op_pkg::exu_word_t value;
  } exu_result_t;

endpackage

/* rtl/exu_dispatch_port.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_dispatch_port (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   dispatch_valid,
  input  exu_bus_pkg::exu_uop_t  dispatch_uop,
  input  logic                   free_pulse,
  output logic                   alloc_valid,
  output exu_bus_pkg::exu_uop_t  alloc_uop,
  output logic                   dispatch_credit,
  output logic                   credit_overrun
);
  typedef logic [$clog2(`EXU_RS_DEPTH):0] occ_t;

  // Credits currently held by the station side
  occ_t outstanding;

  // Each freed entry goes straight back to the sender
  assign dispatch_credit = free_pulse;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      alloc_valid <= 1'b0;
    end else begin
      alloc_valid <= dispatch_valid;
    end
  end

  always_ff @(posedge clock) begin
    alloc_uop <= dispatch_uop;
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      outstanding    <= '0;
      credit_overrun <= 1'b0;
    end else begin
      // Sender holds no credit when all entries are outstanding and none frees now
      if (dispatch_valid && !free_pulse && outstanding == occ_t'(`EXU_RS_DEPTH)) begin
        credit_overrun <= 1'b1;
      end
      case ({dispatch_valid, free_pulse})
        2'b10: begin
          if (outstanding != occ_t'(`EXU_RS_DEPTH)) begin
            outstanding <= outstanding + 1'b1;
          end
        end
        2'b01: outstanding <= outstanding - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

/* rtl/exu_mul.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_mul (
  input  logic                     clock,
  input  logic                     rst_n,
  input  logic                     mul_issue_valid,
  input  exu_bus_pkg::exu_issue_t  mul_issue,
  output logic                     mul_busy,
  output logic                     mul_out_valid,
  output exu_bus_pkg::exu_result_t mul_out
);
  import exu_op_pkg::*;

  typedef enum logic [1:0] {
    mul_idle,
    mul_run,
    mul_done
  } mul_state_e;

  typedef logic [2*`EXU_XLEN-1:0] dword_t;
  typedef logic [$clog2(`EXU_MUL_CYCLES)-1:0] cnt_t;

  mul_state_e state;
  cnt_t       iter;
  dword_t     mcand;
  dword_t     acc;
  exu_word_t  mplier;
  exu_op_e    op_q;
  exu_tag_t   dest_q;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= mul_idle;
      iter  <= '0;
    end else begin
      case (state)
        mul_idle: begin
          if (mul_issue_valid) begin
            state <= mul_run;
            iter  <= '0;
          end
        end
        mul_run: begin
          iter <= iter + 1'b1;
          if (iter == cnt_t'(`EXU_MUL_CYCLES - 1)) begin
            state <= mul_done;
          end
        end
        default: state <= mul_idle;
      endcase
    end
  end

  // Shift-add datapath, one multiplier bit per cycle
  always_ff @(posedge clock) begin
    if (state == mul_idle && mul_issue_valid) begin
      mcand  <= dword_t'(mul_issue.a);
      mplier <= mul_issue.b;
      acc    <= '0;
      op_q   <= mul_issue.op;
      dest_q <= mul_issue.dest;
    end else if (state == mul_run) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign mul_busy      = state != mul_idle;
  assign mul_out_valid = state == mul_done;
  assign mul_out.dest  = dest_q;
  assign mul_out.value = (op_q == op_mulhu) ? acc[2*`EXU_XLEN-1:`EXU_XLEN]
                                            : acc[`EXU_XLEN-1:0];

endmodule

/* rtl/exu_op_pkg.sv */
`include "exu_params.svh"

package exu_op_pkg;

  typedef logic [`EXU_XLEN-1:0] exu_word_t;

  // Tag 0 means the operand value is present
  typedef logic [`EXU_TAG_W-1:0] exu_tag_t;

  // Opcodes with 3'b111 on top go to the multiplier
  typedef enum logic [3:0] {
    op_add   = 4'b0000,
    op_sub   = 4'b0001,
    op_and   = 4'b0010,
    op_or    = 4'b0011,
    op_xor   = 4'b0100,
    op_sll   = 4'b0101,
    op_srl   = 4'b0110,
    op_sra   = 4'b0111,
    op_slt   = 4'b1000,
    op_sltu  = 4'b1001,
    op_mul   = 4'b1110,
    op_mulhu = 4'b1111
  } exu_op_e;

  function automatic logic exu_is_mul(input exu_op_e op);
    return op[3:1] == 3'b111;
  endfunction

endpackage

/* rtl/exu_params.svh */
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// Data word width
`define EXU_XLEN 32

// ROB tag width, tag 0 is reserved for no dependency
`define EXU_TAG_W 4

// Reservation station entries
`define EXU_RS_DEPTH 4

// Initial reorder-buffer credits
`define EXU_RESULT_CREDITS 2

// Shift-add iterations per multiply
`define EXU_MUL_CYCLES 32

`endif

/* rtl/exu_rs.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_rs (
  input  logic                     clock,
  input  logic                     rst_n,
  input  logic                     alloc_valid,
  input  exu_bus_pkg::exu_uop_t    alloc_uop,
  input  logic                     result_valid,
  input  exu_bus_pkg::exu_result_t result,
  input  logic                     alu_slot_free,
  input  logic                     mul_slot_free,
  input  logic                     mul_busy,
  output logic                     alu_issue_valid,
  output exu_bus_pkg::exu_issue_t  alu_issue,
  output logic                     mul_issue_valid,
  output exu_bus_pkg::exu_issue_t  mul_issue,
  output logic                     free_pulse
);
  import exu_op_pkg::*;
  import exu_bus_pkg::*;

  typedef logic [$clog2(`EXU_RS_DEPTH)-1:0] rs_idx_t;

  logic [`EXU_RS_DEPTH-1:0] rs_valid;
  exu_uop_t                 rs_ent[`EXU_RS_DEPTH];
  logic [`EXU_RS_DEPTH-1:0] rs_ready;

  rs_idx_t  free_idx;
  rs_idx_t  alu_idx;
  rs_idx_t  mul_idx;
  logic     free_found;
  logic     alu_found;
  logic     mul_found;
  exu_uop_t alloc_woken;

  // Tag match against the result bus
  function automatic exu_uop_t wake(input exu_uop_t e, input logic bvalid,
                                    input exu_result_t b);
    exu_uop_t w;
    w = e;
    if (bvalid && e.qj != '0 && e.qj == b.dest) begin
      w.vj = b.value;
      w.qj = '0;
    end
    if (bvalid && e.qk != '0 && e.qk == b.dest) begin
      w.vk = b.value;
      w.qk = '0;
    end
    return w;
  endfunction

  // First free slot, lowest-index ready entry per unit
  always_comb begin
    free_found = 1'b0;
    alu_found  = 1'b0;
    mul_found  = 1'b0;
    free_idx   = '0;
    alu_idx    = '0;
    mul_idx    = '0;
    for (int i = 0; i < `EXU_RS_DEPTH; i++) begin
      rs_ready[i] = rs_valid[i] && rs_ent[i].qj == '0 && rs_ent[i].qk == '0;
      if (!rs_valid[i] && !free_found) begin
        free_idx   = rs_idx_t'(i);
        free_found = 1'b1;
      end
      if (rs_ready[i] && !exu_is_mul(rs_ent[i].op) && !alu_found) begin
        alu_idx   = rs_idx_t'(i);
        alu_found = 1'b1;
      end
      if (rs_ready[i] && exu_is_mul(rs_ent[i].op) && !mul_found) begin
        mul_idx   = rs_idx_t'(i);
        mul_found = 1'b1;
      end
    end
  end

  assign alloc_woken = wake(alloc_uop, result_valid, result);

  // At most one entry frees per cycle, so the ALU goes first
  assign alu_issue_valid = alu_found && alu_slot_free;
  assign mul_issue_valid = mul_found && mul_slot_free && !mul_busy && !alu_issue_valid;
  assign free_pulse      = alu_issue_valid || mul_issue_valid;

  always_comb begin
    alu_issue.op   = rs_ent[alu_idx].op;
    alu_issue.a    = rs_ent[alu_idx].vj;
    alu_issue.b    = rs_ent[alu_idx].vk;
    alu_issue.dest = rs_ent[alu_idx].dest;
    mul_issue.op   = rs_ent[mul_idx].op;
    mul_issue.a    = rs_ent[mul_idx].vj;
    mul_issue.b    = rs_ent[mul_idx].vk;
    mul_issue.dest = rs_ent[mul_idx].dest;
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rs_valid <= '0;
    end else begin
      if (alu_issue_valid) begin
        rs_valid[alu_idx] <= 1'b0;
      end
      if (mul_issue_valid) begin
        rs_valid[mul_idx] <= 1'b0;
      end
      if (alloc_valid && free_found) begin
        rs_valid[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < `EXU_RS_DEPTH; i++) begin
      rs_ent[i] <= wake(rs_ent[i], result_valid, result);
    end
    if (alloc_valid && free_found) begin
      rs_ent[free_idx] <= alloc_woken;
    end
  end

endmodule

/* rtl/exu_top.sv */
`timescale 1ns/1ps

module exu_top (
  input  logic                     clock,
  input  logic                     rst_n,
  input  logic                     dispatch_valid,
  input  exu_bus_pkg::exu_uop_t    dispatch_uop,
  output logic                     dispatch_credit,
  output logic                     result_valid,
  output exu_bus_pkg::exu_result_t result,
  input  logic                     result_credit,
  output logic                     credit_overrun
);
  import exu_bus_pkg::*;

  logic        alloc_valid;
  exu_uop_t    alloc_uop;
  logic        free_pulse;
  logic        alu_issue_valid;
  exu_issue_t  alu_issue;
  logic        mul_issue_valid;
  exu_issue_t  mul_issue;
  logic        mul_busy;
  logic        alu_out_valid;
  exu_result_t alu_out;
  logic        mul_out_valid;
  exu_result_t mul_out;
  logic        alu_slot_free;
  logic        mul_slot_free;

  exu_dispatch_port u_dispatch (
    .clock           (clock),
    .rst_n           (rst_n),
    .dispatch_valid  (dispatch_valid),
    .dispatch_uop    (dispatch_uop),
    .free_pulse      (free_pulse),
    .alloc_valid     (alloc_valid),
    .alloc_uop       (alloc_uop),
    .dispatch_credit (dispatch_credit),
    .credit_overrun  (credit_overrun)
  );

  // Result bus also feeds wakeup
  exu_rs u_rs (
    .clock           (clock),
    .rst_n           (rst_n),
    .alloc_valid     (alloc_valid),
    .alloc_uop       (alloc_uop),
    .result_valid    (result_valid),
    .result          (result),
    .alu_slot_free   (alu_slot_free),
    .mul_slot_free   (mul_slot_free),
    .mul_busy        (mul_busy),
    .alu_issue_valid (alu_issue_valid),
    .alu_issue       (alu_issue),
    .mul_issue_valid (mul_issue_valid),
    .mul_issue       (mul_issue),
    .free_pulse      (free_pulse)
  );

  exu_alu u_alu (
    .alu_issue_valid (alu_issue_valid),
    .alu_issue       (alu_issue),
    .alu_out_valid   (alu_out_valid),
    .alu_out         (alu_out)
  );

  exu_mul u_mul (
    .clock           (clock),
    .rst_n           (rst_n),
    .mul_issue_valid (mul_issue_valid),
    .mul_issue       (mul_issue),
    .mul_busy        (mul_busy),
    .mul_out_valid   (mul_out_valid),
    .mul_out         (mul_out)
  );

  exu_writeback u_writeback (
    .clock           (clock),
    .rst_n           (rst_n),
    .alu_out_valid   (alu_out_valid),
    .alu_out         (alu_out),
    .mul_out_valid   (mul_out_valid),
    .mul_out         (mul_out),
    .result_credit   (result_credit),
    .alu_slot_free   (alu_slot_free),
    .mul_slot_free   (mul_slot_free),
    .result_valid    (result_valid),
    .result          (result)
  );

endmodule

/* rtl/exu_writeback.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_writeback (
  input  logic                     clock,
  input  logic                     rst_n,
  input  logic                     alu_out_valid,
  input  exu_bus_pkg::exu_result_t alu_out,
  input  logic                     mul_out_valid,
  input  exu_bus_pkg::exu_result_t mul_out,
  input  logic                     result_credit,
  output logic                     alu_slot_free,
  output logic                     mul_slot_free,
  output logic                     result_valid,
  output exu_bus_pkg::exu_result_t result
);
  import exu_bus_pkg::*;

  typedef logic [$clog2(`EXU_RESULT_CREDITS):0] credit_t;

  credit_t     credits;
  logic        alu_full;
  logic        mul_full;
  exu_result_t alu_slot;
  exu_result_t mul_slot;
  logic        alu_take;
  logic        mul_take;
  logic        spend;

  // Multiplier slot wins when both hold a result
  assign mul_take = mul_full && credits != '0;
  assign alu_take = alu_full && credits != '0 && !mul_full;
  assign spend    = alu_take || mul_take;

  // A draining slot can be refilled at the same edge
  assign alu_slot_free = !alu_full || alu_take;
  assign mul_slot_free = !mul_full || mul_take;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      alu_full     <= 1'b0;
      mul_full     <= 1'b0;
      result_valid <= 1'b0;
      credits      <= credit_t'(`EXU_RESULT_CREDITS);
    end else begin
      if (alu_out_valid) begin
        alu_full <= 1'b1;
      end else if (alu_take) begin
        alu_full <= 1'b0;
      end
      if (mul_out_valid) begin
        mul_full <= 1'b1;
      end else if (mul_take) begin
        mul_full <= 1'b0;
      end
      result_valid <= spend;
      case ({spend, result_credit})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (alu_out_valid) begin
      alu_slot <= alu_out;
    end
    if (mul_out_valid) begin
      mul_slot <= mul_out;
    end
    result <= mul_take ? mul_slot : alu_slot;
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module exu_tb -f tb.f -o exu_sim

./obj_dir/exu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log || ! grep -q "Simulation completed successfully" sim.log; then
  echo "RESULT: FAIL"
  exit 1
fi
echo "RESULT: PASS"

/* tb.f */
+incdir+rtl
rtl/exu_op_pkg.sv
rtl/exu_bus_pkg.sv
rtl/exu_dispatch_port.sv
rtl/exu_rs.sv
rtl/exu_alu.sv
rtl/exu_mul.sv
rtl/exu_writeback.sv
rtl/exu_top.sv
bench/exu_props.sv
bench/exu_tb.sv
